//--- common/transfer_pkg.sv
// Shared widths and reset values for the transfer subsystem
package transfer_pkg;

	// Address and data widths
	localparam int ADDR_W = 28; // Byte address
	localparam int DATA_W = 32; // One memory word

	// Byte step between consecutive words
	localparam logic [2:0] BYTES_PER_WORD = 3'd4;

	// On-chip memory geometry
	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = 8; // Word index, log2 of MEM_WORDS

	// Master buffering, sized for the largest burst
	localparam int FIFO_DEPTH = 4;

	// Burst switch, value k moves k+1 words
	localparam int BURST_W = 2;

	// Power-up contents of the sequencer registers
	localparam logic [DATA_W-1:0] WRITE_SEED = 32'hf00f_beeb;
	localparam logic [DATA_W-1:0] READ_RESET_VALUE = 32'hfeed_feed;

endpackage

//--- master/read_master.sv
`timescale 1ns/10ps

// Fetches a run of words from memory into a user-facing FIFO
module read_master (
	input logic clk,
	input logic reset,
	// Control side
	input logic read_go,
	input logic [transfer_pkg::ADDR_W-1:0] read_base,
	input logic [transfer_pkg::ADDR_W-1:0] read_length, // Bytes
	output logic read_done,
	// User data side
	input logic read_buffer,
	output logic read_available,
	output logic [transfer_pkg::DATA_W-1:0] read_word,
	// Memory read port
	output logic mem_read,
	output logic [transfer_pkg::ADDR_W-1:0] mem_read_addr,
	input logic [transfer_pkg::DATA_W-1:0] mem_read_data
);

	logic [transfer_pkg::ADDR_W-1:0] read_addr;
	logic [transfer_pkg::ADDR_W-1:0] req_left; // Reads not yet issued
	logic [transfer_pkg::ADDR_W-1:0] recv_left; // Words not yet returned
	logic rd_valid; // Memory data lands this cycle
	logic fifo_empty;
	logic [$clog2(transfer_pkg::FIFO_DEPTH):0] fifo_count;
	logic [$clog2(transfer_pkg::FIFO_DEPTH)+1:0] in_flight;

	word_fifo user_fifo (
		.clk(clk),
		.reset(reset),
		.push(rd_valid),
		.push_data(mem_read_data),
		.pop(read_buffer),
		.head(read_word),
		.empty(fifo_empty),
		.full(),
		.count(fifo_count)
	);

	// Stored words plus the one in the memory pipe
	assign in_flight = fifo_count + rd_valid;

	// Issue only when a slot is guaranteed for the returning word
	assign mem_read = (req_left != '0) && (in_flight < transfer_pkg::FIFO_DEPTH);
	assign mem_read_addr = read_addr;
	assign read_available = !fifo_empty;

	// Request side
	always_ff @(posedge clk) begin
		if (!reset) begin
			read_addr <= '0;
			req_left <= '0;
		end else if (read_go) begin
			read_addr <= read_base;
			req_left <= {2'b00, read_length[transfer_pkg::ADDR_W-1:2]};
		end else if (mem_read) begin
			read_addr <= read_addr + transfer_pkg::BYTES_PER_WORD;
			req_left <= req_left - 1'b1;
		end
	end

	// One-cycle memory latency
	always_ff @(posedge clk) begin
		if (!reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= mem_read;
	end

	// Receive side, done follows the last word into the FIFO
	always_ff @(posedge clk) begin
		if (!reset) begin
			recv_left <= '0;
			read_done <= 1'b0;
		end else if (read_go) begin
			recv_left <= {2'b00, read_length[transfer_pkg::ADDR_W-1:2]};
			read_done <= 1'b0;
		end else if (rd_valid) begin
			recv_left <= recv_left - 1'b1;
			if (recv_left == 1)
				read_done <= 1'b1;
		end
	end

endmodule

//--- master/word_fifo.sv
`timescale 1ns/10ps

// Show-ahead FIFO, head is valid whenever empty is low
module word_fifo (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [transfer_pkg::DATA_W-1:0] push_data,
	input logic pop,
	output logic [transfer_pkg::DATA_W-1:0] head,
	output logic empty,
	output logic full,
	output logic [$clog2(transfer_pkg::FIFO_DEPTH):0] count
);

	logic [transfer_pkg::DATA_W-1:0] entries [transfer_pkg::FIFO_DEPTH];
	logic [$clog2(transfer_pkg::FIFO_DEPTH)-1:0] wr_ptr; // Next free slot
	logic [$clog2(transfer_pkg::FIFO_DEPTH)-1:0] rd_ptr; // Oldest entry
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = count[$clog2(transfer_pkg::FIFO_DEPTH)]; // MSB set only at depth
	assign do_push = push && !full; // Overflow push is dropped
	assign do_pop = pop && !empty;
	assign head = entries[rd_ptr]; // Show-ahead read

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= push_data;
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

//--- master/write_master.sv
`timescale 1ns/10ps

// Drains buffered user words into sequential memory writes
module write_master (
	input logic clk,
	input logic reset,
	// Control side
	input logic write_go,
	input logic [transfer_pkg::ADDR_W-1:0] write_base,
	input logic [transfer_pkg::ADDR_W-1:0] write_length, // Bytes
	output logic write_done,
	// User data side
	input logic write_buffer,
	input logic [transfer_pkg::DATA_W-1:0] write_data,
	output logic write_full,
	// Memory write port
	output logic mem_write,
	output logic [transfer_pkg::ADDR_W-1:0] mem_write_addr,
	output logic [transfer_pkg::DATA_W-1:0] mem_write_data
);

	logic [transfer_pkg::ADDR_W-1:0] words_left; // Words still to store
	logic [transfer_pkg::ADDR_W-1:0] write_addr;
	logic [transfer_pkg::DATA_W-1:0] fifo_head;
	logic fifo_empty;

	// User words wait here until the memory takes them
	word_fifo user_fifo (
		.clk(clk),
		.reset(reset),
		.push(write_buffer),
		.push_data(write_data),
		.pop(mem_write), // One word retired per write
		.head(fifo_head),
		.empty(fifo_empty),
		.full(write_full),
		.count()
	);

	// Write whenever a word is ready and the run is not finished
	assign mem_write = !fifo_empty && (words_left != '0);
	assign mem_write_addr = write_addr;
	assign mem_write_data = fifo_head;

	always_ff @(posedge clk) begin
		if (!reset) begin
			words_left <= '0;
			write_addr <= '0;
			write_done <= 1'b0;
		end else if (write_go) begin
			// New run, length arrives in bytes
			write_addr <= write_base;
			words_left <= {2'b00, write_length[transfer_pkg::ADDR_W-1:2]};
			write_done <= 1'b0;
		end else if (mem_write) begin
			write_addr <= write_addr + transfer_pkg::BYTES_PER_WORD;
			words_left <= words_left - 1'b1;
			if (words_left == 1)
				write_done <= 1'b1; // Held until next go
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the transfer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module transfer_tb \
	-f transfer_system.f \
	--Mdir obj_dir \
	-o transfer_sim

./obj_dir/transfer_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- sim/transfer_tb.sv
`timescale 1ns/10ps

// Random command testbench for transfer_top with a reference model
module transfer_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int DIRECTED_COMMANDS = 10;
	localparam int RANDOM_COMMANDS = 300;
	localparam int CYCLES_PER_COMMAND = 40; // Press, transfer and four display checks
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 10
		+ (DIRECTED_COMMANDS + RANDOM_COMMANDS) * CYCLES_PER_COMMAND;

	logic clk = 1'b0;
	logic reset;
	logic rdwr_cntl;
	logic n_action;
	logic add_data_sel;
	logic [transfer_pkg::BURST_W-1:0] burst_words;
	logic indicator;
	logic busy;
	logic [transfer_pkg::DATA_W-1:0] display_data;

	// Reference state
	logic [transfer_pkg::ADDR_W-1:0] model_addr;
	logic [transfer_pkg::DATA_W-1:0] model_pattern; // Last value written
	logic [transfer_pkg::DATA_W-1:0] model_read_data;
	logic [transfer_pkg::DATA_W-1:0] model_mem [transfer_pkg::MEM_WORDS];

	int error_count;
	int check_count;
	int command_count;

	transfer_top dut (
		.clk(clk),
		.reset(reset),
		.rdwr_cntl(rdwr_cntl),
		.n_action(n_action),
		.add_data_sel(add_data_sel),
		.burst_words(burst_words),
		.indicator(indicator),
		.busy(busy),
		.display_data(display_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Compare and count
	task automatic check_value(input string name, input logic [transfer_pkg::DATA_W-1:0] actual,
			input logic [transfer_pkg::DATA_W-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Display value the switches should select
	function automatic logic [transfer_pkg::DATA_W-1:0] expected_display(input logic wr,
			input logic sel);
		if (sel)
			return {{(transfer_pkg::DATA_W-transfer_pkg::ADDR_W){1'b0}}, model_addr};
		else if (wr)
			return '0; // Write mode shows nothing
		else
			return model_read_data;
	endfunction

	// Applies one command to the model, tells whether the DUT should accept it
	task automatic apply_model(input logic wr, input int words, output logic accepted);
		logic [transfer_pkg::ADDR_W-1:0] run_bytes;
		logic [transfer_pkg::MEM_AW-1:0] index;
		int bytes_int;
		int i;
		bytes_int = words * 4;
		run_bytes = bytes_int[transfer_pkg::ADDR_W-1:0];
		accepted = 1'b1;
		if (wr) begin
			for (i = 0; i < words; i++) begin
				model_pattern = model_pattern + 32'd4; // Stepped before each word
				index = model_addr[transfer_pkg::MEM_AW+1:2] + i[transfer_pkg::MEM_AW-1:0];
				model_mem[index] = model_pattern;
			end
			model_addr = model_addr + run_bytes;
		end else if (model_addr >= run_bytes) begin
			model_addr = model_addr - run_bytes;
			// Last word of the run is the one kept
			bytes_int = words - 1;
			index = model_addr[transfer_pkg::MEM_AW+1:2] + bytes_int[transfer_pkg::MEM_AW-1:0];
			model_read_data = model_mem[index];
		end else begin
			accepted = 1'b0; // Not enough room below the address
		end
	endtask

	// Idle outputs in all four switch positions
	task automatic check_idle_outputs();
		logic wr;
		logic sel;
		int combo;
		for (combo = 0; combo < 4; combo++) begin
			wr = combo[1];
			sel = combo[0];
			@(posedge clk);
			rdwr_cntl <= wr;
			add_data_sel <= sel;
			@(negedge clk); // Outputs settled
			check_value("display_data", display_data, expected_display(wr, sel));
			check_value("indicator", 32'(indicator), 32'((model_addr != '0) && !wr));
			check_value("busy", 32'(busy), 32'd0);
		end
	endtask

	// One button press, then wait for the command to finish
	task automatic run_command(input logic wr, input logic [transfer_pkg::BURST_W-1:0] burst,
			input logic sel);
		logic accepted;
		int words;
		words = int'(burst) + 1;
		apply_model(wr, words, accepted);
		@(posedge clk);
		rdwr_cntl <= wr;
		burst_words <= burst;
		add_data_sel <= sel;
		n_action <= 1'b0;
		@(posedge clk);
		n_action <= 1'b1; // Press lasts one cycle
		@(negedge clk);
		check_value("busy", 32'(busy), 32'(accepted)); // Ignored reads stay idle
		while (busy)
			@(negedge clk); // Watchdog covers a stuck busy
		command_count++;
		check_value("display_data", display_data, expected_display(wr, sel)); // Switches as pressed
		check_idle_outputs();
	endtask

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run still going after %0d cycles, busy never fell", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [31:0] rand_word;
		int cmd;
		void'($urandom(32'h6f3));
		reset = 1'b0;
		rdwr_cntl = 1'b0;
		n_action = 1'b1; // Button released
		add_data_sel = 1'b1;
		burst_words = '0;
		error_count = 0;
		check_count = 0;
		command_count = 0;
		model_addr = '0;
		model_pattern = transfer_pkg::WRITE_SEED;
		model_read_data = transfer_pkg::READ_RESET_VALUE;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;

		// Power-up values
		check_idle_outputs();

		// Directed sequence, edge cases first
		run_command(1'b0, 2'd0, 1'b1); // Read at address 0, ignored
		run_command(1'b1, 2'd3, 1'b1); // Four words
		run_command(1'b1, 2'd1, 1'b0);
		run_command(1'b1, 2'd0, 1'b1);
		run_command(1'b0, 2'd2, 1'b0); // Back three words
		run_command(1'b0, 2'd3, 1'b1); // Down to zero
		run_command(1'b0, 2'd0, 1'b0); // Ignored again
		run_command(1'b1, 2'd2, 1'b1);
		run_command(1'b0, 2'd3, 1'b0); // 16 bytes above 12, ignored
		run_command(1'b0, 2'd2, 1'b1);

		// Random mix
		for (cmd = 0; cmd < RANDOM_COMMANDS; cmd++) begin
			rand_word = $urandom;
			run_command(rand_word[0], rand_word[2:1], rand_word[3]);
		end

		$display("Summary: %0d commands, %0d checks, %0d errors",
			command_count, check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- source/transfer_sequencer.sv
`timescale 1ns/10ps

// Turns switch and button commands into master transfers
module transfer_sequencer (
	input logic clk,
	input logic reset,
	input logic rdwr_cntl, // High selects write
	input logic n_action, // Active-low command button
	input logic add_data_sel, // High shows the address
	input logic [transfer_pkg::BURST_W-1:0] burst_words,
	output logic indicator,
	output logic busy,
	output logic [transfer_pkg::DATA_W-1:0] display_data,
	// Write master
	output logic write_go,
	output logic [transfer_pkg::ADDR_W-1:0] write_base,
	output logic [transfer_pkg::ADDR_W-1:0] write_length,
	input logic write_done,
	output logic write_buffer,
	output logic [transfer_pkg::DATA_W-1:0] write_data,
	input logic write_full,
	// Read master
	output logic read_go,
	output logic [transfer_pkg::ADDR_W-1:0] read_base,
	output logic [transfer_pkg::ADDR_W-1:0] read_length,
	input logic read_done,
	output logic read_buffer,
	input logic read_available,
	input logic [transfer_pkg::DATA_W-1:0] read_word
);

	typedef enum logic [2:0] {
		IDLE,
		WRITE_PUSH, // Feed words, go with the first
		WRITE_WAIT,
		READ_GO,
		READ_WAIT,
		READ_POP // Drain the read FIFO
	} state_t;

	state_t state;
	logic [transfer_pkg::ADDR_W-1:0] address;
	logic [transfer_pkg::DATA_W-1:0] pattern; // Last written value
	logic [transfer_pkg::DATA_W-1:0] read_data;
	logic [transfer_pkg::BURST_W:0] req_words; // From the switch
	logic [transfer_pkg::BURST_W:0] run_words; // Latched per command
	logic [transfer_pkg::BURST_W:0] word_count;
	logic [transfer_pkg::ADDR_W-1:0] req_bytes;
	logic [transfer_pkg::ADDR_W-1:0] run_bytes;
	logic last_word;

	assign req_words = {1'b0, burst_words} + 1'b1;
	assign req_bytes = {{(transfer_pkg::ADDR_W-transfer_pkg::BURST_W-3){1'b0}}, req_words, 2'b00};
	assign run_bytes = {{(transfer_pkg::ADDR_W-transfer_pkg::BURST_W-3){1'b0}}, run_words, 2'b00};
	assign last_word = (word_count == run_words - 1'b1);

	// Both masters start at the current address
	assign write_base = address;
	assign write_length = run_bytes;
	assign write_data = pattern + transfer_pkg::BYTES_PER_WORD; // Step before use
	assign read_base = address;
	assign read_length = run_bytes;

	assign busy = (state != IDLE);
	assign indicator = (address != '0) && !rdwr_cntl;
	assign display_data = add_data_sel
		? {{(transfer_pkg::DATA_W-transfer_pkg::ADDR_W){1'b0}}, address}
		: (rdwr_cntl ? '0 : read_data);

	// Strobes
	always_comb begin
		write_go = 1'b0;
		write_buffer = 1'b0;
		read_go = 1'b0;
		read_buffer = 1'b0;
		case (state)
			WRITE_PUSH: begin
				write_buffer = !write_full;
				write_go = (word_count == '0); // FIFO is empty here, first push lands
			end
			READ_GO: read_go = 1'b1;
			READ_POP: read_buffer = read_available;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
			address <= '0;
			pattern <= transfer_pkg::WRITE_SEED;
			read_data <= transfer_pkg::READ_RESET_VALUE;
			run_words <= '0;
			word_count <= '0;
		end else begin
			case (state)
				IDLE: begin
					word_count <= '0;
					if (!n_action) begin
						run_words <= req_words;
						if (rdwr_cntl) begin
							state <= WRITE_PUSH;
						end else if (address >= req_bytes) begin // Else ignored
							address <= address - req_bytes; // Step back over the run
							state <= READ_GO;
						end
					end
				end
				WRITE_PUSH: begin
					if (write_buffer) begin
						pattern <= write_data;
						word_count <= word_count + 1'b1;
						if (last_word)
							state <= WRITE_WAIT;
					end
				end
				WRITE_WAIT: begin
					if (write_done) begin
						address <= address + run_bytes; // Past the run
						state <= IDLE;
					end
				end
				READ_GO: state <= READ_WAIT;
				READ_WAIT: begin
					if (read_done) // Whole run now buffered
						state <= READ_POP;
				end
				READ_POP: begin
					if (read_buffer) begin
						read_data <= read_word; // Last one wins
						word_count <= word_count + 1'b1;
						if (last_word)
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- source/transfer_top.sv
`timescale 1ns/10ps

// Sequencer, both masters and the word memory
module transfer_top (
	input logic clk,
	input logic reset,
	input logic rdwr_cntl,
	input logic n_action,
	input logic add_data_sel,
	input logic [transfer_pkg::BURST_W-1:0] burst_words,
	output logic indicator,
	output logic busy,
	output logic [transfer_pkg::DATA_W-1:0] display_data
);

	// Write path
	logic write_go;
	logic [transfer_pkg::ADDR_W-1:0] write_base;
	logic [transfer_pkg::ADDR_W-1:0] write_length;
	logic write_done;
	logic write_buffer;
	logic [transfer_pkg::DATA_W-1:0] write_data;
	logic write_full;
	logic mem_write;
	logic [transfer_pkg::ADDR_W-1:0] mem_write_addr;
	logic [transfer_pkg::DATA_W-1:0] mem_write_data;

	// Read path
	logic read_go;
	logic [transfer_pkg::ADDR_W-1:0] read_base;
	logic [transfer_pkg::ADDR_W-1:0] read_length;
	logic read_done;
	logic read_buffer;
	logic read_available;
	logic [transfer_pkg::DATA_W-1:0] read_word;
	logic mem_read;
	logic [transfer_pkg::ADDR_W-1:0] mem_read_addr;
	logic [transfer_pkg::DATA_W-1:0] mem_read_data;

	transfer_sequencer sequencer (
		.clk, .reset, .rdwr_cntl, .n_action, .add_data_sel, .burst_words,
		.indicator, .busy, .display_data,
		.write_go, .write_base, .write_length, .write_done,
		.write_buffer, .write_data, .write_full,
		.read_go, .read_base, .read_length, .read_done,
		.read_buffer, .read_available, .read_word
	);

	write_master writer (
		.clk, .reset,
		.write_go, .write_base, .write_length, .write_done,
		.write_buffer, .write_data, .write_full,
		.mem_write, .mem_write_addr, .mem_write_data
	);

	read_master reader (
		.clk, .reset,
		.read_go, .read_base, .read_length, .read_done,
		.read_buffer, .read_available, .read_word,
		.mem_read, .mem_read_addr, .mem_read_data
	);

	// Separate ports, so no arbitration between masters
	word_memory memory (
		.clk,
		.mem_write, .mem_write_addr, .mem_write_data,
		.mem_read, .mem_read_addr, .mem_read_data
	);

endmodule

//--- source/word_memory.sv
`timescale 1ns/10ps

// Simple dual-port word RAM, registered read
module word_memory (
	input logic clk,
	input logic mem_write,
	input logic [transfer_pkg::ADDR_W-1:0] mem_write_addr,
	input logic [transfer_pkg::DATA_W-1:0] mem_write_data,
	input logic mem_read,
	input logic [transfer_pkg::ADDR_W-1:0] mem_read_addr,
	output logic [transfer_pkg::DATA_W-1:0] mem_read_data
);

	logic [transfer_pkg::DATA_W-1:0] words [transfer_pkg::MEM_WORDS];

	// Byte address to word index, upper bits wrap
	always_ff @(posedge clk) begin
		if (mem_write)
			words[mem_write_addr[transfer_pkg::MEM_AW+1:2]] <= mem_write_data;
		if (mem_read) // Data valid next cycle
			mem_read_data <= words[mem_read_addr[transfer_pkg::MEM_AW+1:2]];
	end

endmodule

//--- transfer_system.f
common/transfer_pkg.sv
master/word_fifo.sv
master/write_master.sv
master/read_master.sv
source/word_memory.sv
source/transfer_sequencer.sv
source/transfer_top.sv
sim/transfer_tb.sv
